/* filelist.f */
rtl/timePkg.sv
rtl/ppsStatusIf.sv
rtl/ppsInput.sv
rtl/timeCounter.sv
rtl/ppsOutput.sv
rtl/timeControl.sv
rtl/timeService.sv
bench/timeServiceTb.sv

/* Bender.yml */
package:
  name: time_service

sources:
  - rtl/timePkg.sv
  - rtl/ppsStatusIf.sv
  - rtl/ppsInput.sv
  - rtl/timeCounter.sv
  - rtl/ppsOutput.sv
  - rtl/timeControl.sv
  - rtl/timeService.sv
  - target: test
    files:
      - bench/timeServiceTb.sv

/* bench/timeServiceTb.sv */
/*
  Testbench for the time-of-day service. Runs reset, time set, PPS lock and
  loss, output modes, delta time and sticky clear with a 1000-tick second.
*/
`timescale 1ns/1ps

module timeServiceTb;
  import timePkg::*;

  localparam int clkPeriod = 10;
  localparam int driveDelay = 1;
  localparam int tbTicksPerSecond = 1000;
  localparam int pulseCycles = 5;
  // about 15 PPS periods over all tests with margin
  localparam int testCycles = 15500;
  localparam longint fracLimit = ((64'd1 << 32) / tbTicksPerSecond) * 5;
  // status bits that are neither sticky, live nor edge count
  localparam logic [31:0] reservedMask = 32'h43ff_ff00;

  logic CLK;
  logic arstN;
  logic [63:0] timeIn;
  logic doSetTime;
  logic doDeltaTime;
  logic doSetControl;
  logic doClear;
  logic ppsSyncIn;
  logic [31:0] statusOut;
  logic [2:0] controlOut;
  logic [27:0] ticksPerPps;
  logic [63:0] timeNow;
  logic [63:0] deltaTime;
  logic ppsSyncOut;

  integer seed;
  int checkCount;
  int errorCount;
  int testCount;
  int testStartErrors;
  bit countDrive;
  int driveHigh;

  timeService #(
    .ticksPerSecond(tbTicksPerSecond)
  ) i_timeService (
    .CLK(CLK),
    .arstN(arstN),
    .timeIn(timeIn),
    .doSetTime(doSetTime),
    .doDeltaTime(doDeltaTime),
    .doSetControl(doSetControl),
    .doClear(doClear),
    .ppsSyncIn(ppsSyncIn),
    .statusOut(statusOut),
    .controlOut(controlOut),
    .ticksPerPps(ticksPerPps),
    .timeNow(timeNow),
    .deltaTime(deltaTime),
    .ppsSyncOut(ppsSyncOut)
  );

  initial
  begin
    CLK = 1'b0;
    forever #(clkPeriod / 2) CLK = ~CLK;
  end

  initial
  begin
    #(testCycles * clkPeriod * 13 / 10);
    $display("watchdog expired before the tests completed");
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    checkCount++;
    assert (actual === expected)
    else
    begin
      errorCount++;
      $display("Error %s expected %h got %h", name, expected, actual);
    end
  endtask

  task automatic checkRange(input string name, input longint lo, input longint hi,
                            input longint actual);
    checkCount++;
    assert (actual >= lo && actual <= hi)
    else
    begin
      errorCount++;
      $display("Error %s expected %h..%h got %h", name, lo, hi, actual);
    end
  endtask

  // all outputs held at zero while in reset
  always @(negedge CLK)
  begin
    if (!arstN)
    begin
      checkValue("statusOut", 64'd0, statusOut);
      checkValue("controlOut", 64'd0, controlOut);
      checkValue("timeNow", 64'd0, timeNow);
      checkValue("deltaTime", 64'd0, deltaTime);
      checkValue("ticksPerPps", 64'd0, ticksPerPps);
      checkValue("ppsSyncOut", 64'd0, ppsSyncOut);
    end
  end

  // reserved status bits never set
  always @(negedge CLK)
  begin
    checkValue("statusOut reserved", 64'd0, statusOut & reservedMask);
  end

  always @(negedge CLK)
  begin
    if (countDrive && ppsSyncOut)
      driveHigh++;
  end

  task automatic waitCycles(input int count);
    repeat (count)
    begin
      @(posedge CLK);
    end
    #(driveDelay);
  endtask

  task automatic finishTest(input string name);
    testCount++;
    $display("test %s done, %0d errors", name, errorCount - testStartErrors);
    testStartErrors = errorCount;
  endtask

  task automatic setTime(input logic [63:0] value);
    timeIn = value;
    doSetTime = 1'b1;
    waitCycles(1);
    doSetTime = 1'b0;
    waitCycles(1);
    checkValue("timeNow", value, timeNow);
    checkValue("timeSetSticky", 64'd1, statusOut[statusTimeSetStickyBit]);
  endtask

  task automatic writeControl(input logic [2:0] value);
    timeIn = {61'd0, value};
    doSetControl = 1'b1;
    waitCycles(1);
    doSetControl = 1'b0;
    checkValue("controlOut", value, controlOut);
  endtask

  task automatic clearSticky();
    doClear = 1'b1;
    waitCycles(1);
    doClear = 1'b0;
  endtask

  // counts cycles until the seconds field moves and then checks the step
  task automatic measureSecond(output int cycles);
    logic [31:0] secBefore;
    secBefore = timeNow[63:32];
    cycles = 0;
    while (timeNow[63:32] == secBefore && cycles < 1100)
    begin
      waitCycles(1);
      cycles++;
    end
    checkValue("timeNow.seconds", {32'd0, secBefore + 32'd1}, timeNow[63:32]);
  endtask

  // five cycle PPS pulse with an optional check of the locked second step
  task automatic firePulse(input bit checkStep);
    logic [31:0] secBefore;
    secBefore = timeNow[63:32];
    ppsSyncIn = 1'b1;
    waitCycles(pulseCycles);
    if (checkStep)
    begin
      checkValue("timeNow.seconds", {32'd0, secBefore + 32'd1}, timeNow[63:32]);
      checkRange("timeNow.fraction", 0, fracLimit, timeNow[31:0]);
    end
    ppsSyncIn = 1'b0;
  endtask

  task automatic waitForLoss(input int limit);
    int cycles;
    bit sawLost;
    cycles = 0;
    sawLost = 1'b0;
    while ((statusOut[statusPpsOkBit] || !statusOut[statusLostStickyBit]) && cycles < limit)
    begin
      waitCycles(1);
      cycles++;
      // live lost bit pulses as lock drops
      if (statusOut[statusPpsLostBit])
        sawLost = 1'b1;
    end
    checkCount++;
    assert (!statusOut[statusPpsOkBit] && statusOut[statusLostStickyBit])
    else
    begin
      errorCount++;
      $display("lock loss was not reported within %0d cycles", limit);
    end
    checkValue("ppsLost", 64'd1, sawLost);
  endtask

  initial
  begin
    logic [63:0] value;
    logic [63:0] expected;
    logic [7:0] edgeBefore;
    logic prevOut;
    bit history [0:31];
    int cycles;

    seed = 32'hada48f41;
    checkCount = 0;
    errorCount = 0;
    testCount = 0;
    testStartErrors = 0;
    countDrive = 1'b0;
    driveHigh = 0;
    arstN = 1'b0;
    timeIn = '0;
    doSetTime = 1'b0;
    doDeltaTime = 1'b0;
    doSetControl = 1'b0;
    doClear = 1'b0;
    ppsSyncIn = 1'b0;

    waitCycles(10);
    arstN = 1'b1;
    waitCycles(1);
    checkValue("statusOut", 64'd0, statusOut);
    checkValue("controlOut", 64'd0, controlOut);
    checkValue("timeNow", 64'd0, timeNow);
    checkValue("deltaTime", 64'd0, deltaTime);
    checkValue("ticksPerPps", 64'd0, ticksPerPps);
    checkValue("ppsSyncOut", 64'd0, ppsSyncOut);
    finishTest("reset");

    value = {$random(seed), $random(seed)};
    setTime(value);
    measureSecond(cycles);
    checkRange("first second cycles", 1, 1002, cycles);
    measureSecond(cycles);
    checkRange("second period cycles", 998, 1002, cycles);
    finishTest("set and free run");

    // first pulse is out of window and the second one locks
    firePulse(1'b0);
    waitCycles(995);
    firePulse(1'b0);
    checkValue("ppsOk", 64'd1, statusOut[statusPpsOkBit]);
    checkValue("ppsInSticky", 64'd1, statusOut[statusInStickyBit]);
    waitCycles(995);
    repeat (3)
    begin
      edgeBefore = statusOut[7:0];
      firePulse(1'b1);
      checkValue("ticksPerPps", tbTicksPerSecond, ticksPerPps);
      checkValue("edgeCount", {56'd0, edgeBefore + 8'd1}, statusOut[7:0]);
      waitCycles(995);
    end
    finishTest("pps lock");

    waitForLoss(10);
    clearSticky();
    checkValue("ppsLostSticky", 64'd0, statusOut[statusLostStickyBit]);
    firePulse(1'b0);
    waitCycles(995);
    firePulse(1'b0);
    checkValue("ppsOk", 64'd1, statusOut[statusPpsOkBit]);
    // late pulse
    waitCycles(1095);
    firePulse(1'b0);
    checkValue("ppsOk", 64'd0, statusOut[statusPpsOkBit]);
    checkValue("ppsLostSticky", 64'd1, statusOut[statusLostStickyBit]);
    finishTest("pps loss");

    writeControl(3'b011);
    repeat (20)
    begin
      checkValue("ppsSyncOut", 64'd0, ppsSyncOut);
      waitCycles(1);
    end
    writeControl(3'b010);
    prevOut = ppsSyncOut;
    repeat (20)
    begin
      waitCycles(1);
      checkValue("ppsSyncOut", !prevOut, ppsSyncOut);
      prevOut = ppsSyncOut;
    end
    // loopback with the detector frozen
    writeControl(3'b101);
    edgeBefore = statusOut[7:0];
    for (int i = 0; i < 32; i++)
    begin
      if (i >= 2)
        checkValue("ppsSyncOut", history[i - 2], ppsSyncOut);
      history[i] = $random(seed) & 1;
      ppsSyncIn = history[i];
      waitCycles(1);
    end
    ppsSyncIn = 1'b0;
    waitCycles(3);
    firePulse(1'b0);
    waitCycles(995);
    checkValue("edgeCount", edgeBefore, statusOut[7:0]);
    writeControl(3'b000);
    firePulse(1'b0);
    waitCycles(995);
    firePulse(1'b0);
    waitCycles(995);
    driveHigh = 0;
    countDrive = 1'b1;
    firePulse(1'b0);
    waitCycles(995);
    countDrive = 1'b0;
    checkRange("ppsSyncOut high cycles", 898, 902, driveHigh);
    finishTest("control and outputs");

    // keeps lock for the rest of the test
    firePulse(1'b0);
    value = {$random(seed), $random(seed)};
    setTime(value);
    timeIn = {$random(seed), $random(seed)};
    // time still shows the loaded value at the next edge
    expected = value - timeIn;
    doDeltaTime = 1'b1;
    waitCycles(1);
    doDeltaTime = 1'b0;
    checkValue("deltaTime", expected, deltaTime);
    clearSticky();
    checkValue("ppsLostSticky", 64'd0, statusOut[statusLostStickyBit]);
    checkValue("ppsInSticky", 64'd0, statusOut[statusInStickyBit]);
    checkValue("timeSetSticky", 64'd0, statusOut[statusTimeSetStickyBit]);
    checkValue("ppsOk", 64'd1, statusOut[statusPpsOkBit]);
    finishTest("delta and clear");

    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* rtl/timeService.sv */
/*
  Time-of-day service top level. Connects the PPS detector, time counter,
  PPS output and control/status blocks to the host strobes and pins.
*/
`timescale 1ns/1ps

module timeService #(
  parameter int unsigned ticksPerSecond = timePkg::defaultTicksPerSecond
) (
  input logic CLK,
  input logic arstN,
  input logic [timePkg::timeWidth-1:0] timeIn,
  input logic doSetTime,
  input logic doDeltaTime,
  input logic doSetControl,
  input logic doClear,
  input logic ppsSyncIn,
  output logic [timePkg::statusWidth-1:0] statusOut,
  output logic [timePkg::controlWidth-1:0] controlOut,
  output logic [timePkg::tickWidth-1:0] ticksPerPps,
  output logic [timePkg::timeWidth-1:0] timeNow,
  output logic [timePkg::timeWidth-1:0] deltaTime,
  output logic ppsSyncOut
);
  import timePkg::*;

  logic secondStep;

  ppsStatusIf ppsBus ();

  assign ticksPerPps = ppsBus.ticksPerPps;

  ppsInput #(
    .ticksPerSecond(ticksPerSecond)
  ) i_ppsInput (
    .CLK(CLK),
    .arstN(arstN),
    .ppsSyncIn(ppsSyncIn),
    .ppsDisable(controlOut[ctlDisablePpsBit]),
    .pps(ppsBus.source)
  );

  timeCounter #(
    .ticksPerSecond(ticksPerSecond)
  ) i_timeCounter (
    .CLK(CLK),
    .arstN(arstN),
    .timeIn(timeIn),
    .doSetTime(doSetTime),
    .pps(ppsBus.sink),
    .secondStep(secondStep),
    .timeNow(timeNow)
  );

  ppsOutput #(
    .ticksPerSecond(ticksPerSecond)
  ) i_ppsOutput (
    .CLK(CLK),
    .arstN(arstN),
    .outMode(ppsOutMode_e'(controlOut[ctlOutModeLsb +: 2])),
    .secondStep(secondStep),
    .pps(ppsBus.sink),
    .ppsSyncOut(ppsSyncOut)
  );

  timeControl i_timeControl (
    .CLK(CLK),
    .arstN(arstN),
    .timeIn(timeIn),
    .timeNow(timeNow),
    .doSetTime(doSetTime),
    .doDeltaTime(doDeltaTime),
    .doSetControl(doSetControl),
    .doClear(doClear),
    .pps(ppsBus.sink),
    .controlReg(controlOut),
    .deltaTime(deltaTime),
    .statusOut(statusOut)
  );

endmodule

/* rtl/timeControl.sv */
/*
  Control register, sticky status bits and time difference. Packs the
  status word read by the host.
*/
`timescale 1ns/1ps

module timeControl (
  input logic CLK,
  input logic arstN,
  input timePkg::timeValue_t timeIn,
  input timePkg::timeValue_t timeNow,
  input logic doSetTime,
  input logic doDeltaTime,
  input logic doSetControl,
  input logic doClear,
  ppsStatusIf.sink pps,
  output logic [timePkg::controlWidth-1:0] controlReg,
  output timePkg::timeValue_t deltaTime,
  output logic [timePkg::statusWidth-1:0] statusOut
);
  import timePkg::*;

  logic timeSetSticky;
  logic ppsInSticky;
  logic ppsLostSticky;

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      controlReg <= '0;
      deltaTime <= '0;
      timeSetSticky <= 1'b0;
      ppsInSticky <= 1'b0;
      ppsLostSticky <= 1'b0;
    end
    else
    begin
      if (doSetControl)
      begin
        controlReg <= timeIn[controlWidth-1:0];
      end
      if (doDeltaTime)
      begin
        deltaTime <= timeNow - timeIn;
      end
      // clear wins over a set in the same cycle
      if (doClear)
      begin
        timeSetSticky <= 1'b0;
        ppsInSticky <= 1'b0;
        ppsLostSticky <= 1'b0;
      end
      else
      begin
        if (doSetTime)
          timeSetSticky <= 1'b1;
        if (pps.ppsOk)
          ppsInSticky <= 1'b1;
        if (pps.ppsLost)
          ppsLostSticky <= 1'b1;
      end
    end
  end

  always_comb
  begin
    statusOut = '0;
    statusOut[statusLostStickyBit] = ppsLostSticky;
    statusOut[statusInStickyBit] = ppsInSticky;
    statusOut[statusTimeSetStickyBit] = timeSetSticky;
    statusOut[statusPpsOkBit] = pps.ppsOk;
    statusOut[statusPpsLostBit] = pps.ppsLost;
    statusOut[edgeCountWidth-1:0] = pps.edgeCount;
  end

endmodule

/* rtl/ppsOutput.sv */
/*
  Outgoing PPS generator. Drives a pulse each second, loops back the
  synchronized input, toggles at half the clock rate or stays low.
*/
`timescale 1ns/1ps

module ppsOutput #(
  parameter int unsigned ticksPerSecond = timePkg::defaultTicksPerSecond
) (
  input logic CLK,
  input logic arstN,
  input timePkg::ppsOutMode_e outMode,
  input logic secondStep,
  ppsStatusIf.sink pps,
  output logic ppsSyncOut
);
  import timePkg::*;

  localparam logic [tickWidth-1:0] driveTicks =
    tickWidth'(64'(ticksPerSecond) * driveDutyPercent / 100);

  logic restart;
  logic [tickWidth-1:0] driveLeft;
  logic driveBit;
  logic halfClock;

  // period starts on the PPS edge when locked, else on the local second
  assign restart = pps.ppsOk ? pps.validEdge : secondStep;

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      driveLeft <= '0;
      driveBit <= 1'b0;
      halfClock <= 1'b0;
    end
    else
    begin
      // counts down the high part of the period
      if (restart)
      begin
        driveLeft <= driveTicks;
      end
      else if (driveLeft != '0)
      begin
        driveLeft <= driveLeft - 1'b1;
      end
      driveBit <= (driveLeft != '0);
      halfClock <= !halfClock;
    end
  end

  always_comb
  begin
    case (outMode)
      modeDrive: ppsSyncOut = driveBit;
      modeLoopback: ppsSyncOut = pps.syncLevel;
      modeHalfClock: ppsSyncOut = halfClock;
      default: ppsSyncOut = 1'b0;
    endcase
  end

endmodule

/* rtl/timeCounter.sv */
/*
  Seconds and fraction counter. Free runs from a fixed increment, steps on
  valid PPS edges while locked, and loads on a time set.
*/
`timescale 1ns/1ps

module timeCounter #(
  parameter int unsigned ticksPerSecond = timePkg::defaultTicksPerSecond
) (
  input logic CLK,
  input logic arstN,
  input timePkg::timeValue_t timeIn,
  input logic doSetTime,
  ppsStatusIf.sink pps,
  output logic secondStep,
  output timePkg::timeValue_t timeNow
);
  import timePkg::*;

  // visible fraction sits just below the two wrap bits
  localparam int unsigned fracLsb = accWidth - 2 - fracWidth;
  localparam logic [accWidth-1:0] fracInc =
    accWidth'((64'd1 << (accWidth - 2)) / ticksPerSecond);

  logic [accWidth-1:0] fracAcc;
  logic [1:0] prevWrap;
  logic [secWidth-1:0] secCount;
  logic wrapChange;
  logic ppsStep;

  assign wrapChange = fracAcc[accWidth-1 -: 2] != prevWrap;
  assign ppsStep = pps.ppsOk ? pps.validEdge : wrapChange;
  assign secondStep = ppsStep && !doSetTime;

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      fracAcc <= '0;
      prevWrap <= '0;
      secCount <= '0;
      timeNow <= '0;
    end
    else
    begin
      prevWrap <= fracAcc[accWidth-1 -: 2];
      if (doSetTime)
      begin
        // wrap bits kept so the load is not seen as a second
        secCount <= timeIn.seconds;
        fracAcc <= {fracAcc[accWidth-1 -: 2], timeIn.fraction, {fracLsb{1'b0}}};
      end
      else
      begin
        if (ppsStep)
        begin
          secCount <= secCount + 1'b1;
        end
        if (pps.ppsOk && pps.validEdge)
        begin
          fracAcc <= {fracAcc[accWidth-1 -: 2], {(accWidth - 2){1'b0}}};
        end
        else
        begin
          fracAcc <= fracAcc + fracInc;
        end
      end
      timeNow.seconds <= secCount;
      timeNow.fraction <= fracAcc[fracLsb +: fracWidth];
    end
  end

endmodule

/* rtl/ppsInput.sv */
/*
  PPS input detector. Synchronizes the external pulse, checks each rising
  edge against the tolerance window, tracks lock and measures the period.
*/
`timescale 1ns/1ps

module ppsInput #(
  parameter int unsigned ticksPerSecond = timePkg::defaultTicksPerSecond
) (
  input logic CLK,
  input logic arstN,
  input logic ppsSyncIn,
  input logic ppsDisable,
  ppsStatusIf.source pps
);
  import timePkg::*;

  // tolerance never drops below one tick on slow clocks
  localparam int unsigned tolerance =
    (ticksPerSecond / windowDivisor > 0) ? ticksPerSecond / windowDivisor : 1;
  localparam logic [tickWidth-1:0] lowerBound = tickWidth'(ticksPerSecond - tolerance);
  localparam logic [tickWidth-1:0] upperBound = tickWidth'(ticksPerSecond + tolerance);

  logic syncMeta;
  logic syncLevel;
  logic prevLevel;
  logic [tickWidth-1:0] sinceRise;
  logic [tickWidth-1:0] periodReg;
  logic [edgeCountWidth-1:0] edgeCount;
  ppsLockState_e lockState;
  logic validEdge;
  logic ppsLost;
  logic rise;
  logic inWindow;
  logic timeout;

  assign rise = syncLevel && !prevLevel && !ppsDisable;
  assign inWindow = (sinceRise > lowerBound) && (sinceRise < upperBound);
  assign timeout = sinceRise >= upperBound;

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      syncMeta <= 1'b0;
      syncLevel <= 1'b0;
      prevLevel <= 1'b0;
      sinceRise <= '0;
      periodReg <= '0;
      edgeCount <= '0;
      lockState <= searching;
      validEdge <= 1'b0;
      ppsLost <= 1'b0;
    end
    else
    begin
      syncMeta <= ppsSyncIn;
      syncLevel <= syncMeta;
      validEdge <= rise && inWindow;
      ppsLost <= 1'b0;
      // detector frozen while disabled
      if (!ppsDisable)
      begin
        prevLevel <= syncLevel;
        if (rise)
        begin
          sinceRise <= tickWidth'(1);
          edgeCount <= edgeCount + 1'b1;
        end
        else if (sinceRise != '1)
        begin
          sinceRise <= sinceRise + 1'b1;
        end
        if (rise && inWindow)
        begin
          periodReg <= sinceRise;
        end
        case (lockState)
          searching:
          begin
            if (rise && inWindow)
            begin
              lockState <= locked;
            end
          end
          locked:
          begin
            // stray edge or missing pulse drops lock
            if ((rise && !inWindow) || timeout)
            begin
              lockState <= searching;
              ppsLost <= 1'b1;
            end
          end
          default: lockState <= searching;
        endcase
      end
    end
  end

  assign pps.syncLevel = syncLevel;
  assign pps.validEdge = validEdge;
  assign pps.ppsOk = (lockState == locked);
  assign pps.ppsLost = ppsLost;
  assign pps.edgeCount = edgeCount;
  assign pps.ticksPerPps = periodReg;

endmodule

/* rtl/ppsStatusIf.sv */
/*
  PPS detector results. Driven by the input detector, read by the time
  counter, the PPS output and the control/status block.
*/
`timescale 1ns/1ps

interface ppsStatusIf;
  import timePkg::*;

  logic syncLevel;
  logic validEdge;
  logic ppsOk;
  logic ppsLost;
  logic [edgeCountWidth-1:0] edgeCount;
  logic [tickWidth-1:0] ticksPerPps;

  modport source (
    output syncLevel, validEdge, ppsOk, ppsLost, edgeCount, ticksPerPps
  );

  modport sink (
    input syncLevel, validEdge, ppsOk, ppsLost, edgeCount, ticksPerPps
  );

endinterface

/* rtl/timePkg.sv */
/*
  Shared widths, tick constants, status bit positions and types for the
  time-of-day service. Modules import it inside their bodies.
*/
package timePkg;

  // time value layout
  localparam int unsigned timeWidth = 64;
  localparam int unsigned secWidth = 32;
  localparam int unsigned fracWidth = 32;

  // fraction accumulator, top two bits detect the second wrap
  localparam int unsigned accWidth = 50;

  localparam int unsigned tickWidth = 28;
  localparam int unsigned edgeCountWidth = 8;
  localparam int unsigned controlWidth = 3;
  localparam int unsigned statusWidth = 32;

  // reference clock and PPS window
  localparam int unsigned defaultTicksPerSecond = 200000000;
  localparam int unsigned windowDivisor = 1000;
  localparam int unsigned driveDutyPercent = 90;

  // control register fields
  localparam int unsigned ctlOutModeLsb = 0;
  localparam int unsigned ctlDisablePpsBit = 2;

  // status word, edge count in the low byte
  localparam int unsigned statusLostStickyBit = 31;
  localparam int unsigned statusInStickyBit = 29;
  localparam int unsigned statusTimeSetStickyBit = 28;
  localparam int unsigned statusPpsOkBit = 27;
  localparam int unsigned statusPpsLostBit = 26;

  typedef enum logic [1:0] {
    modeDrive,
    modeLoopback,
    modeHalfClock,
    modeOff
  } ppsOutMode_e;

  typedef enum logic {
    searching,
    locked
  } ppsLockState_e;

  typedef struct packed {
    logic [secWidth-1:0] seconds;
    logic [fracWidth-1:0] fraction;
  } timeValue_t;

endpackage
